// File: include/eth_tx_params.svh
`ifndef ETH_TX_PARAMS_SVH
`define ETH_TX_PARAMS_SVH

// ----------------------------------------
// packet ring
// ----------------------------------------
`define ETH_PACKET_SIZE     64
`define ETH_ADDR_W          6
`define ETH_LEN_W           7      // must hold ETH_PACKET_SIZE itself
`define ETH_RING_DEPTH      4
`define ETH_SLOT_W          2

// ----------------------------------------
// frame layout
// ----------------------------------------
`define ETH_PREAMBLE_BYTES  7
`define ETH_PREAMBLE_BYTE   8'h55
`define ETH_SFD_BYTE        8'hD5
`define ETH_FCS_BYTES       4
`define ETH_GAP_CYCLES      12     // idle cycles between frames

`endif

// File: design/eth_tx_pkg.sv
`include "eth_tx_params.svh"

package eth_tx_pkg;

    typedef logic [7:0]               byte_t;
    typedef logic [`ETH_ADDR_W-1:0]   pkt_addr_t;
    typedef logic [`ETH_LEN_W-1:0]    pkt_len_t;
    typedef logic [`ETH_SLOT_W-1:0]   slot_t;    // wraps around the ring by itself

    // host operations, all on the same start strobe
    typedef enum logic [1:0] {
        OP_WRITE,
        OP_WRITE_LEN,
        OP_WRITE_NEXT
    } host_op_t;

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_PREAMBLE,
        TX_SFD,
        TX_DATA,
        TX_FCS,
        TX_GAP
    } tx_state_t;

endpackage

// File: design/host_port.sv
`timescale 1ns/1ns
`include "eth_tx_params.svh"

module host_port import eth_tx_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      start,
    input  host_op_t  op,
    input  pkt_len_t  address,     // one bit wider than a slot address for the bounds check
    input  byte_t     value,
    input  pkt_len_t  fill_len,
    input  slot_t     send_ptr,
    output logic      done,
    output pkt_len_t  result,
    output slot_t     fill_ptr,
    output logic      byte_we,
    output pkt_addr_t byte_addr,
    output byte_t     byte_data,
    output logic      len_we,
    output pkt_len_t  len_data
);

    logic     clear_pending;   // new slot length still to be zeroed
    logic     in_range;
    logic     wr_op;
    logic     grow;
    logic     ring_full;
    pkt_len_t cur_len;
    pkt_len_t new_len;

    assign in_range  = address < `ETH_PACKET_SIZE;
    assign new_len   = address + 1'b1;
    assign cur_len   = clear_pending ? '0 : fill_len;
    assign wr_op     = start && (op == OP_WRITE) && in_range;
    assign grow      = wr_op && (new_len > cur_len);
    assign ring_full = slot_t'(fill_ptr + 1'b1) == send_ptr;

    assign byte_we   = wr_op;
    assign byte_addr = address[`ETH_ADDR_W-1:0];
    assign byte_data = value;
    assign len_we    = grow || clear_pending;
    assign len_data  = grow ? new_len : '0;   // a write right after a commit wins over the clear

    always_ff @(posedge clock) begin
        if (reset) begin
            done          <= 1'b0;
            result        <= '0;
            fill_ptr      <= '0;
            clear_pending <= 1'b0;
        end else begin
            done          <= start;
            clear_pending <= 1'b0;
            if (start) begin
                case (op)
                    OP_WRITE:     result <= in_range ? pkt_len_t'(0) : pkt_len_t'(1);
                    OP_WRITE_LEN: result <= cur_len;
                    OP_WRITE_NEXT: begin
                        if (ring_full) begin
                            result <= pkt_len_t'(1);
                        end else begin
                            result        <= '0;
                            fill_ptr      <= fill_ptr + 1'b1;
                            clear_pending <= 1'b1;
                        end
                    end
                    default:      result <= '0;
                endcase
            end
        end
    end

endmodule

// File: design/packet_ring.sv
`timescale 1ns/1ns
`include "eth_tx_params.svh"

module packet_ring import eth_tx_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  slot_t     fill_ptr,
    input  logic      byte_we,
    input  pkt_addr_t byte_addr,
    input  byte_t     byte_data,
    input  logic      len_we,
    input  pkt_len_t  len_data,
    input  slot_t     rd_slot,
    input  pkt_addr_t rd_addr,
    output pkt_len_t  fill_len,
    output pkt_len_t  rd_len,
    output byte_t     rd_data
);

    // ----------------------------------------
    // storage
    // ----------------------------------------
    byte_t    slot_mem  [0:`ETH_RING_DEPTH-1][0:`ETH_PACKET_SIZE-1];
    pkt_len_t len_table [0:`ETH_RING_DEPTH-1];

    // host side always writes into the slot being filled
    always_ff @(posedge clock) begin
        if (byte_we) begin
            slot_mem[fill_ptr][byte_addr] <= byte_data;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `ETH_RING_DEPTH; i++) begin
                len_table[i] <= '0;
            end
        end else if (len_we) begin
            len_table[fill_ptr] <= len_data;
        end
    end

    // ----------------------------------------
    // read ports
    // ----------------------------------------
    assign fill_len = len_table[fill_ptr];
    assign rd_len   = len_table[rd_slot];   // transmit side
    assign rd_data  = slot_mem[rd_slot][rd_addr];

endmodule

// File: design/tx_phase_counter.sv
`timescale 1ns/1ns
`include "eth_tx_params.svh"

module tx_phase_counter import eth_tx_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  logic     clear,
    input  pkt_len_t limit,
    output pkt_len_t count,
    output logic     last
);

    logic [`ETH_LEN_W:0] count_inc;   // extra bit so the compare never wraps

    assign count_inc = count + 1'b1;

    // also true straight away for a limit of zero or one
    assign last = count_inc >= {1'b0, limit};

    always_ff @(posedge clock) begin
        if (reset || clear) begin
            count <= '0;
        end else begin
            count <= count_inc[`ETH_LEN_W-1:0];
        end
    end

endmodule

// File: design/fcs_crc32.sv
`timescale 1ns/1ns
`include "eth_tx_params.svh"

module fcs_crc32 import eth_tx_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       init,
    input  logic       update,
    input  byte_t      data,
    input  logic [1:0] index,
    output byte_t      fcs_byte
);

    // register kept msb first, bit reversal on the way out gives the reflected crc
    logic [31:0] crc;
    byte_t       crc_sel;

    function automatic logic [31:0] crc_step(input logic [31:0] c_in, input byte_t d);
        logic [31:0] c;
        logic        fb;
        c = c_in;
        for (int i = 0; i < 8; i++) begin   // bit 0 goes on the wire first
            fb = c[31] ^ d[i];
            c  = {c[30:0], 1'b0} ^ (fb ? 32'h04C1_1DB7 : 32'h0);
        end
        return c;
    endfunction

    function automatic byte_t reverse_byte(input byte_t b);
        byte_t r;
        for (int i = 0; i < 8; i++) begin
            r[i] = b[7-i];
        end
        return r;
    endfunction

    always_ff @(posedge clock) begin
        if (reset || init) begin
            crc <= '1;
        end else if (update) begin
            crc <= crc_step(crc, data);
        end
    end

    // ----------------------------------------
    // check byte, least significant first
    // ----------------------------------------
    always_comb begin
        case (index)
            2'd0:    crc_sel = crc[31:24];
            2'd1:    crc_sel = crc[23:16];
            2'd2:    crc_sel = crc[15:8];
            default: crc_sel = crc[7:0];
        endcase
    end

    assign fcs_byte = ~reverse_byte(crc_sel);

endmodule

// File: design/tx_frame_fsm.sv
`timescale 1ns/1ns
`include "eth_tx_params.svh"

module tx_frame_fsm import eth_tx_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  slot_t      fill_ptr,
    input  pkt_len_t   rd_len,
    input  byte_t      rd_data,
    input  pkt_len_t   count,
    input  logic       last,
    input  byte_t      fcs_byte,
    output slot_t      send_ptr,
    output slot_t      rd_slot,
    output pkt_addr_t  rd_addr,
    output logic       cnt_clear,
    output pkt_len_t   cnt_limit,
    output logic       crc_init,
    output logic       crc_update,
    output logic [1:0] fcs_index,
    output byte_t      tx_data,
    output logic       tx_en
);

    tx_state_t state;
    tx_state_t state_next;
    byte_t     byte_next;
    logic      en_next;
    logic      pending;

    assign pending    = send_ptr != fill_ptr;
    assign rd_slot    = send_ptr;
    assign rd_addr    = count[`ETH_ADDR_W-1:0];
    assign fcs_index  = count[1:0];
    assign cnt_clear  = last;                    // each phase restarts the count
    assign crc_init   = state == TX_PREAMBLE;
    assign crc_update = state == TX_DATA;

    always_comb begin
        state_next = state;
        cnt_limit  = '0;
        byte_next  = '0;
        en_next    = 1'b1;
        case (state)
            TX_IDLE: begin
                en_next = 1'b0;
                if (pending) state_next = TX_PREAMBLE;
            end
            TX_PREAMBLE: begin
                cnt_limit = pkt_len_t'(`ETH_PREAMBLE_BYTES);
                byte_next = `ETH_PREAMBLE_BYTE;
                if (last) state_next = TX_SFD;
            end
            TX_SFD: begin
                cnt_limit  = pkt_len_t'(1);
                byte_next  = `ETH_SFD_BYTE;
                state_next = (rd_len == '0) ? TX_FCS : TX_DATA;   // empty packet
            end
            TX_DATA: begin
                cnt_limit = rd_len;
                byte_next = rd_data;
                if (last) state_next = TX_FCS;
            end
            TX_FCS: begin
                cnt_limit = pkt_len_t'(`ETH_FCS_BYTES);
                byte_next = fcs_byte;
                if (last) state_next = TX_GAP;
            end
            TX_GAP: begin
                cnt_limit = pkt_len_t'(`ETH_GAP_CYCLES);
                en_next   = 1'b0;
                if (last) state_next = pending ? TX_PREAMBLE : TX_IDLE;
            end
            default: begin
                en_next    = 1'b0;
                state_next = TX_IDLE;
            end
        endcase
    end

    // outputs follow the state by one cycle
    always_ff @(posedge clock) begin
        if (reset) begin
            state    <= TX_IDLE;
            send_ptr <= '0;
            tx_en    <= 1'b0;
            tx_data  <= '0;
        end else begin
            state   <= state_next;
            tx_en   <= en_next;
            tx_data <= byte_next;
            if (state == TX_FCS && last) send_ptr <= send_ptr + 1'b1;
        end
    end

endmodule

// File: design/eth_tx_top.sv
`timescale 1ns/1ns
`include "eth_tx_params.svh"

module eth_tx_top import eth_tx_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  logic     start,
    input  host_op_t op,
    input  pkt_len_t address,
    input  byte_t    value,
    output logic     done,
    output pkt_len_t result,
    output byte_t    tx_data,
    output logic     tx_en
);

    slot_t      fill_ptr, send_ptr, rd_slot;
    pkt_len_t   fill_len, len_data, rd_len, count, cnt_limit;
    pkt_addr_t  byte_addr, rd_addr;
    byte_t      byte_data, rd_data, fcs_byte;
    logic       byte_we, len_we, cnt_clear, last, crc_init, crc_update;
    logic [1:0] fcs_index;

    host_port u_host (
        .clock(clock), .reset(reset), .start(start), .op(op),
        .address(address), .value(value), .fill_len(fill_len), .send_ptr(send_ptr),
        .done(done), .result(result), .fill_ptr(fill_ptr), .byte_we(byte_we),
        .byte_addr(byte_addr), .byte_data(byte_data), .len_we(len_we), .len_data(len_data)
    );

    packet_ring u_ring (
        .clock(clock), .reset(reset), .fill_ptr(fill_ptr), .byte_we(byte_we),
        .byte_addr(byte_addr), .byte_data(byte_data), .len_we(len_we), .len_data(len_data),
        .rd_slot(rd_slot), .rd_addr(rd_addr), .fill_len(fill_len), .rd_len(rd_len),
        .rd_data(rd_data)
    );

    tx_phase_counter u_cnt (
        .clock(clock), .reset(reset), .clear(cnt_clear), .limit(cnt_limit),
        .count(count), .last(last)
    );

    // crc sees the same byte that goes out in the data phase
    fcs_crc32 u_crc (
        .clock(clock), .reset(reset), .init(crc_init), .update(crc_update),
        .data(rd_data), .index(fcs_index), .fcs_byte(fcs_byte)
    );

    tx_frame_fsm u_fsm (
        .clock(clock), .reset(reset), .fill_ptr(fill_ptr), .rd_len(rd_len),
        .rd_data(rd_data), .count(count), .last(last), .fcs_byte(fcs_byte),
        .send_ptr(send_ptr), .rd_slot(rd_slot), .rd_addr(rd_addr), .cnt_clear(cnt_clear),
        .cnt_limit(cnt_limit), .crc_init(crc_init), .crc_update(crc_update),
        .fcs_index(fcs_index), .tx_data(tx_data), .tx_en(tx_en)
    );

endmodule

// File: verif/eth_tx_tb.sv
`timescale 1ns/1ns
`include "eth_tx_params.svh"

module eth_tx_tb import eth_tx_pkg::*; ();

    localparam int MAX_ROWS = 32;
    localparam int GAP      = `ETH_GAP_CYCLES;

    logic     clock, reset, start, done, tx_en;
    host_op_t op;
    pkt_len_t address, result;
    byte_t    value, tx_data;

    // ----------------------------------------
    // operation table and ring model
    // ----------------------------------------
    host_op_t tbl_op     [MAX_ROWS];
    pkt_len_t tbl_addr   [MAX_ROWS];
    byte_t    tbl_value  [MAX_ROWS];
    pkt_len_t tbl_result [MAX_ROWS];
    logic     tbl_frame  [MAX_ROWS];
    logic     tbl_drain  [MAX_ROWS];   // wait until every frame is out
    int       rows, frames_total;

    int model_mem [`ETH_RING_DEPTH][`ETH_PACKET_SIZE];   // -1 for never written
    int model_len [`ETH_RING_DEPTH];
    int model_fill;

    // scoreboard and monitor state
    int    exp_len   [$];
    int    exp_bytes [$];
    byte_t rx_bytes  [$];
    int    frames_seen, low_count, cycle_count, timeout_limit;
    logic  gap_armed;

    always #20 clock = ~clock;

    eth_tx_top dut (
        .clock(clock), .reset(reset), .start(start), .op(op), .address(address),
        .value(value), .done(done), .result(result), .tx_data(tx_data), .tx_en(tx_en)
    );

    task automatic stop_run();
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("ERROR: time %0t: %s is 0x%0h, expected 0x%0h",
                     $time, what, got, expected);
            stop_run();
        end
    endtask

    task automatic add_row(input host_op_t o, input int a, input int res,
                           input logic frame, input logic drain);
        tbl_op[rows]     = o;
        tbl_addr[rows]   = pkt_len_t'(a);
        tbl_value[rows]  = byte_t'($urandom());
        tbl_result[rows] = pkt_len_t'(res);
        tbl_frame[rows]  = frame;
        tbl_drain[rows]  = drain;
        frames_total     = frames_total + int'(frame);
        rows++;
    endtask

    // reflected crc-32 in shift right form
    function automatic logic [31:0] crc_byte(input logic [31:0] crc, input byte_t b);
        logic [31:0] c;
        c = crc ^ {24'h0, b};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
        end
        return c;
    endfunction

    task automatic apply_row(input int r);
        int s;
        s = model_fill;
        if (tbl_drain[r]) begin
            while (exp_len.size() != 0 || tx_en) @(negedge clock);
        end
        @(posedge clock);
        #2;
        check_value($sformatf("done before row %0d", r), 32'(done), 32'(0));
        start   = 1'b1;
        op      = tbl_op[r];
        address = tbl_addr[r];
        value   = tbl_value[r];
        @(posedge clock);
        #2;
        start = 1'b0;
        check_value($sformatf("done one cycle after row %0d", r), 32'(done), 32'(1));
        check_value($sformatf("result of row %0d", r), 32'(result), 32'(tbl_result[r]));

        if (tbl_op[r] == OP_WRITE && tbl_addr[r] < `ETH_PACKET_SIZE) begin
            model_mem[s][tbl_addr[r]] = int'(tbl_value[r]);
            if (int'(tbl_addr[r]) + 1 > model_len[s]) model_len[s] = int'(tbl_addr[r]) + 1;
        end
        if (tbl_frame[r]) begin   // committed packet goes to the scoreboard
            exp_len.push_back(model_len[s]);
            for (int i = 0; i < model_len[s]; i++) exp_bytes.push_back(model_mem[s][i]);
            model_fill = (s + 1) % `ETH_RING_DEPTH;
            model_len[model_fill] = 0;
            for (int i = 0; i < `ETH_PACKET_SIZE; i++) model_mem[model_fill][i] = -1;
        end
    endtask

    task automatic check_frame();
        int          n;
        int          expected;
        logic [31:0] crc;
        n   = exp_len.pop_front();
        crc = '1;
        check_value("frame length in cycles", rx_bytes.size(), n + 12);
        for (int i = 0; i < `ETH_PREAMBLE_BYTES; i++) begin
            check_value("preamble byte", rx_bytes[i], `ETH_PREAMBLE_BYTE);
        end
        check_value("start of frame byte", rx_bytes[7], `ETH_SFD_BYTE);
        for (int i = 0; i < n; i++) begin
            expected = exp_bytes.pop_front();
            if (expected >= 0) begin
                check_value($sformatf("data byte %0d", i), rx_bytes[8 + i], expected);
                crc = crc_byte(crc, byte_t'(expected));
            end else begin
                crc = crc_byte(crc, rx_bytes[8 + i]);   // unwritten gap byte
            end
        end
        crc = ~crc;
        for (int i = 0; i < `ETH_FCS_BYTES; i++) begin
            check_value($sformatf("fcs byte %0d", i), rx_bytes[8 + n + i], crc[8*i +: 8]);
        end
        frames_seen++;
    endtask

    // ----------------------------------------
    // frame monitor sampling on the falling edge
    // ----------------------------------------
    always @(negedge clock) begin
        if (tx_en) begin
            if (rx_bytes.size() == 0) begin
                if (exp_len.size() == 0) begin
                    $display("a frame started with no committed packet waiting");
                    stop_run();
                end
                if (gap_armed) check_value("idle cycles between frames", low_count, GAP);
            end
            rx_bytes.push_back(tx_data);
        end else if (rx_bytes.size() != 0) begin
            check_frame();
            rx_bytes.delete();
            low_count = 1;
            gap_armed = exp_len.size() != 0;   // next frame already queued
        end else begin
            low_count++;
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > timeout_limit) begin
            $display("timeout after %0d cycles, the test did not finish", cycle_count);
            stop_run();
        end
    end

    initial begin
        void'($urandom(32'he9d2_5e52));
        clock   = 1'b0;
        reset   = 1'b1;
        start   = 1'b0;
        op      = OP_WRITE;
        address = '0;
        value   = '0;
        rows = 0;
        frames_total = 0;
        frames_seen = 0;
        low_count = 0;
        cycle_count = 0;
        gap_armed = 1'b0;
        model_fill = 0;
        for (int s = 0; s < `ETH_RING_DEPTH; s++) begin
            model_len[s] = 0;
            for (int i = 0; i < `ETH_PACKET_SIZE; i++) model_mem[s][i] = -1;
        end

        add_row(OP_WRITE_LEN, 0, 0, 0, 0);
        for (int a = 0; a < 5; a++) add_row(OP_WRITE, a, 0, 0, 0);
        add_row(OP_WRITE, 9, 0, 0, 0);
        add_row(OP_WRITE_LEN, 0, 10, 0, 0);    // unwritten 5..8 still count
        add_row(OP_WRITE, 64, 1, 0, 0);
        add_row(OP_WRITE_LEN, 0, 10, 0, 0);
        add_row(OP_WRITE_NEXT, 0, 0, 1, 0);
        for (int a = 0; a < 6; a++) add_row(OP_WRITE, a * 3, 0, 0, a == 0);
        add_row(OP_WRITE_LEN, 0, 16, 0, 0);
        repeat (3) add_row(OP_WRITE_NEXT, 0, 0, 1, 0);
        add_row(OP_WRITE_NEXT, 0, 1, 0, 0);     // ring full
        add_row(OP_WRITE_LEN, 0, 0, 0, 0);
        timeout_limit = rows * 4 + frames_total * (12 + `ETH_PACKET_SIZE + GAP) + 100;

        repeat (5) @(posedge clock);
        #2;
        reset = 1'b0;
        for (int r = 0; r < rows; r++) apply_row(r);
        while (frames_seen != frames_total) @(negedge clock);
        repeat (2 * GAP) @(negedge clock);      // no stray frame after the last one
        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+include
design/eth_tx_pkg.sv
design/host_port.sv
design/packet_ring.sv
design/tx_phase_counter.sv
design/fcs_crc32.sv
design/tx_frame_fsm.sv
design/eth_tx_top.sv
verif/eth_tx_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the eth_tx testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary -Wno-fatal -f vlog.f --top-module eth_tx_tb -o eth_tx_sim; then
    echo "build failed"
    exit 1
fi

if ! ./obj_dir/eth_tx_sim > sim.log 2>&1; then
    cat sim.log
    echo "simulation exited with an error"
    exit 1
fi
cat sim.log

if grep -q "Result: PASSED" sim.log; then
    exit 0
fi
exit 1
